// File: src/arm_lite_pkg.sv
// arm_lite_pkg: shared opcode, condition and class codes and the instruction word views
`default_nettype none

package arm_lite_pkg;

	localparam int N_LANES = 4; // read lanes on bits 19:16, 15:12, 11:8, 3:0
	localparam logic [3:0] LR_IDX = 4'd14;

	// data-processing opcodes, ARM encoding
	localparam logic [3:0] OP_AND = 4'b0000;
	localparam logic [3:0] OP_EOR = 4'b0001;
	localparam logic [3:0] OP_SUB = 4'b0010;
	localparam logic [3:0] OP_RSB = 4'b0011;
	localparam logic [3:0] OP_ADD = 4'b0100;
	localparam logic [3:0] OP_CMP = 4'b1010;
	localparam logic [3:0] OP_ORR = 4'b1100;
	localparam logic [3:0] OP_MOV = 4'b1101;
	localparam logic [3:0] OP_BIC = 4'b1110;

	localparam logic [3:0] COND_EQ = 4'h0;
	localparam logic [3:0] COND_NE = 4'h1;
	localparam logic [3:0] COND_CS = 4'h2;
	localparam logic [3:0] COND_CC = 4'h3;
	localparam logic [3:0] COND_MI = 4'h4;
	localparam logic [3:0] COND_PL = 4'h5;
	localparam logic [3:0] COND_VS = 4'h6;
	localparam logic [3:0] COND_VC = 4'h7;
	localparam logic [3:0] COND_HI = 4'h8;
	localparam logic [3:0] COND_LS = 4'h9;
	localparam logic [3:0] COND_GE = 4'hA;
	localparam logic [3:0] COND_LT = 4'hB;
	localparam logic [3:0] COND_GT = 4'hC;
	localparam logic [3:0] COND_LE = 4'hD;
	localparam logic [3:0] COND_AL = 4'hE;

	localparam logic [1:0] CLS_DP = 2'd0;
	localparam logic [1:0] CLS_MUL = 2'd1;
	localparam logic [1:0] CLS_BR = 2'd2;
	localparam logic [1:0] CLS_UNDEF = 2'd3;

	// immediate operand is {imm_hi, rm}, rotated right by 2*rot
	typedef struct packed {
		logic [3:0] cond;
		logic [1:0] fmt; // 00 for data processing
		logic imm;
		logic [3:0] opcode;
		logic s;
		logic [3:0] rn;
		logic [3:0] rd;
		logic [3:0] rot;
		logic [3:0] imm_hi;
		logic [3:0] rm;
	} dp_fmt_t;

	typedef struct packed {
		logic [3:0] cond;
		logic [5:0] fmt; // all zero
		logic acc;
		logic s;
		logic [3:0] rd;
		logic [3:0] rn; // accumulate source
		logic [3:0] rs;
		logic [3:0] tag; // 1001
		logic [3:0] rm;
	} mul_fmt_t;

	typedef struct packed {
		logic [3:0] cond;
		logic [2:0] fmt; // 101
		logic link;
		logic [23:0] offset;
	} br_fmt_t;

	typedef union packed {
		dp_fmt_t dp;
		mul_fmt_t mul;
		br_fmt_t br;
	} instr_u;

endpackage

`default_nettype wire

// File: src/prog_mem.sv
// prog_mem: program word store, loaded and read back over APB, with a registered fetch port
`default_nettype none
`timescale 1ns/1ns

module prog_mem #(
	parameter int PROG_DEPTH = 64
) (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic [31:0] fetch_addr,
	output logic [31:0] fetch_instr
);

	localparam int AW = (PROG_DEPTH > 1) ? $clog2(PROG_DEPTH) : 1;

	logic [31:0] words [PROG_DEPTH];
	logic apb_setup;
	logic apb_access;
	logic apb_hit;
	logic fetch_hit;
	logic [AW-1:0] apb_idx;
	logic [AW-1:0] fetch_idx;

	assign apb_setup = psel && !penable;
	assign apb_access = psel && penable;
	assign apb_hit = paddr[31:2] < 30'(PROG_DEPTH); // byte address, word index above bit 1
	assign apb_idx = paddr[AW+1:2];
	assign fetch_hit = fetch_addr[31:2] < 30'(PROG_DEPTH);
	assign fetch_idx = fetch_addr[AW+1:2];

	assign pready = 1'b1; // never stretches an access
	assign prdata = (apb_access && !pwrite && apb_hit) ? words[apb_idx] : '0;

	// error flag is decided in setup so it lines up with the access cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			pslverr <= 1'b0;
		end else begin
			pslverr <= apb_setup && !apb_hit;
		end
	end

	always_ff @(posedge clk) begin
		if (apb_access && pwrite && apb_hit) begin
			words[apb_idx] <= pwdata;
		end
		fetch_instr <= fetch_hit ? words[fetch_idx] : '0; // zero word past the end
	end

endmodule

`default_nettype wire

// File: src/fetch_stage.sv
// fetch_stage: program counter with branch redirect, tags each fetched word with pc and valid
`default_nettype none
`timescale 1ns/1ns

module fetch_stage #(
	parameter int PROG_DEPTH = 64
) (
	input logic clk,
	input logic rst,
	input logic run,
	input logic flush,
	input logic [31:0] br_target,
	input logic [31:0] mem_instr,
	output logic [31:0] fetch_addr,
	output logic d_valid,
	output arm_lite_pkg::instr_u d_instr,
	output logic [31:0] d_pc
);

	logic [31:0] pc;
	logic pc_in_range;

	assign fetch_addr = pc;
	assign pc_in_range = pc[31:2] < 30'(PROG_DEPTH);

	// instruction half of the fetch register sits in the program memory read port
	assign d_instr = mem_instr;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			d_valid <= 1'b0;
		end else if (flush) begin
			pc <= br_target; // redirect and drop the word in flight
			d_valid <= 1'b0;
		end else begin
			d_valid <= run && pc_in_range; // words past the end never issue
			if (run) begin
				pc <= pc + 32'd4;
			end
		end
	end

	always_ff @(posedge clk) begin
		d_pc <= pc;
	end

endmodule

`default_nettype wire

// File: src/reg_file.sv
// reg_file: sixteen 32-bit registers, combinational read lanes and one write port
`default_nettype none
`timescale 1ns/1ns

module reg_file (
	input logic clk,
	input logic rst,
	input logic [arm_lite_pkg::N_LANES-1:0][3:0] rd_addr,
	input logic wr_en,
	input logic [3:0] wr_addr,
	input logic [31:0] wr_data,
	output logic [arm_lite_pkg::N_LANES-1:0][31:0] rd_data
);

	import arm_lite_pkg::*;

	logic [31:0] regs [16];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// same-cycle write is not visible here, the lanes cover it
	always_comb begin
		for (int i = 0; i < N_LANES; i++) begin
			rd_data[i] = regs[rd_addr[i]];
		end
	end

endmodule

`default_nettype wire

// File: src/operand_fwd.sv
// operand_fwd: one register read lane that picks the freshest value and registers it for execute
`default_nettype none
`timescale 1ns/1ns

module operand_fwd (
	input logic clk,
	input logic rst,
	input logic [3:0] addr,
	input logic [31:0] bank_data,
	input logic x_wr_en,
	input logic [3:0] x_wr_rd,
	input logic [31:0] x_wr_data,
	input logic w_wr_en,
	input logic [3:0] w_wr_rd,
	input logic [31:0] w_wr_data,
	input logic flush,
	output logic [31:0] operand
);

	logic x_hit;
	logic w_hit;
	logic [31:0] fresh;

	assign x_hit = x_wr_en && (x_wr_rd == addr);
	assign w_hit = w_wr_en && (w_wr_rd == addr);

	// execute result is younger than the writeback one
	always_comb begin
		if (x_hit) begin
			fresh = x_wr_data;
		end else if (w_hit) begin
			fresh = w_wr_data; // bank write lands on this same edge
		end else begin
			fresh = bank_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			operand <= '0;
		end else begin
			operand <= fresh;
		end
	end

endmodule

`default_nettype wire

// File: src/exec_stage.sv
// exec_stage: decode, ALU, multiplier, condition check, NZCV flags, branch resolve and writeback
`default_nettype none
`timescale 1ns/1ns

module exec_stage (
	input logic clk,
	input logic rst,
	input logic d_valid,
	input arm_lite_pkg::instr_u d_instr,
	input logic [31:0] d_pc,
	input logic [arm_lite_pkg::N_LANES-1:0][31:0] opnd,
	output logic flush,
	output logic [31:0] br_target,
	output logic x_wr_en,
	output logic [3:0] x_wr_rd,
	output logic [31:0] x_wr_data,
	output logic w_wr_en,
	output logic [3:0] w_wr_rd,
	output logic [31:0] w_wr_data,
	output logic [3:0] flags
);

	import arm_lite_pkg::*;

	function automatic logic [1:0] classify(input instr_u ins);
		logic op_ok;
		logic op2_ok;
		op_ok = ins.dp.opcode inside {OP_AND, OP_EOR, OP_SUB, OP_RSB, OP_ADD,
			OP_ORR, OP_MOV, OP_BIC, OP_CMP};
		op2_ok = ins.dp.imm || ({ins.dp.rot, ins.dp.imm_hi} == 8'h00); // no shifted Rm
		if (ins.mul.fmt == 6'b000000 && ins.mul.tag == 4'b1001)
			return CLS_MUL;
		if (ins.br.fmt == 3'b101)
			return CLS_BR;
		if (ins.dp.fmt == 2'b00 && op_ok && op2_ok && (ins.dp.opcode != OP_CMP || ins.dp.s))
			return CLS_DP;
		return CLS_UNDEF;
	endfunction

	// flags are {N, Z, C, V}
	function automatic logic cond_pass(input logic [3:0] cond, input logic [3:0] f);
		case (cond)
			COND_EQ: return f[2];
			COND_NE: return !f[2];
			COND_CS: return f[1];
			COND_CC: return !f[1];
			COND_MI: return f[3];
			COND_PL: return !f[3];
			COND_VS: return f[0];
			COND_VC: return !f[0];
			COND_HI: return f[1] && !f[2];
			COND_LS: return !f[1] || f[2];
			COND_GE: return f[3] == f[0];
			COND_LT: return f[3] != f[0];
			COND_GT: return !f[2] && (f[3] == f[0]);
			COND_LE: return f[2] || (f[3] != f[0]);
			COND_AL: return 1'b1;
			default: return 1'b0; // NV never executes
		endcase
	endfunction

	logic e_valid;
	instr_u e_instr;
	logic [31:0] e_pc;
	logic [1:0] cls;
	logic fire;
	logic [63:0] rot_wide;
	logic [31:0] imm_val;
	logic op2_c;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] add_x;
	logic [31:0] add_y;
	logic add_ci;
	logic [32:0] sum;
	logic arith;
	logic [31:0] alu_res;
	logic [3:0] dp_nzcv;
	logic [31:0] mul_res;
	logic set_flags;

	assign cls = classify(e_instr);
	assign fire = e_valid && cond_pass(e_instr.dp.cond, flags);

	// imm8 rotated right by twice the rotate field
	assign rot_wide = {2{24'b0, e_instr.dp.imm_hi, e_instr.dp.rm}} >> {e_instr.dp.rot, 1'b0};
	assign imm_val = rot_wide[31:0];
	assign op2_c = (e_instr.dp.imm && e_instr.dp.rot != 4'd0) ? imm_val[31] : flags[1];

	assign op_a = opnd[0];
	assign op_b = e_instr.dp.imm ? imm_val : opnd[3];

	always_comb begin
		add_x = op_a;
		add_y = op_b;
		add_ci = 1'b0;
		case (e_instr.dp.opcode)
			OP_SUB, OP_CMP: begin
				add_y = ~op_b;
				add_ci = 1'b1;
			end
			OP_RSB: begin
				add_x = op_b;
				add_y = ~op_a;
				add_ci = 1'b1;
			end
			default: begin
				add_ci = 1'b0;
			end
		endcase
	end

	assign sum = {1'b0, add_x} + {1'b0, add_y} + {32'b0, add_ci};
	assign arith = e_instr.dp.opcode inside {OP_SUB, OP_RSB, OP_ADD, OP_CMP};

	always_comb begin
		case (e_instr.dp.opcode)
			OP_AND: alu_res = op_a & op_b;
			OP_EOR: alu_res = op_a ^ op_b;
			OP_ORR: alu_res = op_a | op_b;
			OP_MOV: alu_res = op_b;
			OP_BIC: alu_res = op_a & ~op_b;
			default: alu_res = sum[31:0];
		endcase
	end

	assign dp_nzcv = {alu_res[31], alu_res == 32'd0,
		arith ? sum[32] : op2_c, // carry out means no borrow on subtract
		arith ? ((add_x[31] == add_y[31]) && (sum[31] != add_x[31])) : flags[0]};

	// low 32 bits of Rm * Rs, plus Rn for MLA
	assign mul_res = opnd[3] * opnd[2] + (e_instr.mul.acc ? opnd[1] : 32'd0);

	always_comb begin
		x_wr_en = 1'b0;
		x_wr_rd = e_instr.dp.rd;
		x_wr_data = alu_res;
		set_flags = 1'b0;
		case (cls)
			CLS_DP: begin
				x_wr_en = fire && (e_instr.dp.opcode != OP_CMP);
				set_flags = fire && e_instr.dp.s;
			end
			CLS_MUL: begin
				x_wr_en = fire;
				x_wr_rd = e_instr.mul.rd;
				x_wr_data = mul_res;
				set_flags = fire && e_instr.mul.s;
			end
			CLS_BR: begin
				x_wr_en = fire && e_instr.br.link;
				x_wr_rd = LR_IDX;
				x_wr_data = e_pc + 32'd4; // return address
			end
			default: begin
				x_wr_en = 1'b0;
			end
		endcase
	end

	assign flush = fire && (cls == CLS_BR);
	assign br_target = e_pc + 32'd8 + {{6{e_instr.br.offset[23]}}, e_instr.br.offset, 2'b00};

	always_ff @(posedge clk) begin
		if (rst) begin
			e_valid <= 1'b0;
			w_wr_en <= 1'b0;
			flags <= 4'd0;
		end else begin
			e_valid <= d_valid && !flush; // younger slot dies with a taken branch
			w_wr_en <= x_wr_en;
			if (set_flags) begin
				flags <= (cls == CLS_MUL) ? {mul_res[31], mul_res == 32'd0, flags[1:0]} : dp_nzcv;
			end
		end
	end

	always_ff @(posedge clk) begin
		e_instr <= d_instr;
		e_pc <= d_pc;
		w_wr_rd <= x_wr_rd;
		w_wr_data <= x_wr_data;
	end

endmodule

`default_nettype wire

// File: src/core_top.sv
// core_top: four-stage ARM subset core with APB program loading and a retire port
`default_nettype none
`timescale 1ns/1ns

module core_top #(
	parameter int PROG_DEPTH = 64
) (
	input logic clk,
	input logic rst,
	input logic run,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic retire_valid,
	output logic [3:0] retire_rd,
	output logic [31:0] retire_data,
	output logic [3:0] flags
);

	import arm_lite_pkg::*;

	logic [31:0] fetch_addr;
	logic [31:0] mem_instr;
	logic flush;
	logic [31:0] br_target;
	logic d_valid;
	instr_u d_instr;
	logic [31:0] d_pc;
	logic x_wr_en;
	logic [3:0] x_wr_rd;
	logic [31:0] x_wr_data;
	logic [N_LANES-1:0][3:0] lane_addr;
	logic [N_LANES-1:0][31:0] bank_data;
	logic [N_LANES-1:0][31:0] opnd;

	prog_mem #(.PROG_DEPTH(PROG_DEPTH)) u_prog_mem (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.fetch_addr(fetch_addr),
		.fetch_instr(mem_instr)
	);

	fetch_stage #(.PROG_DEPTH(PROG_DEPTH)) u_fetch (
		.clk(clk),
		.rst(rst),
		.run(run),
		.flush(flush),
		.br_target(br_target),
		.mem_instr(mem_instr),
		.fetch_addr(fetch_addr),
		.d_valid(d_valid),
		.d_instr(d_instr),
		.d_pc(d_pc)
	);

	// writeback register doubles as the retire port
	reg_file u_regs (
		.clk(clk),
		.rst(rst),
		.rd_addr(lane_addr),
		.wr_en(retire_valid),
		.wr_addr(retire_rd),
		.wr_data(retire_data),
		.rd_data(bank_data)
	);

	for (genvar i = 0; i < N_LANES; i++) begin : g_lane
		localparam int LO = (i == N_LANES - 1) ? 0 : 16 - 4 * i; // 19:16 15:12 11:8 3:0

		assign lane_addr[i] = d_instr[LO+3:LO];

		operand_fwd u_fwd (
			.clk(clk),
			.rst(rst),
			.addr(lane_addr[i]),
			.bank_data(bank_data[i]),
			.x_wr_en(x_wr_en),
			.x_wr_rd(x_wr_rd),
			.x_wr_data(x_wr_data),
			.w_wr_en(retire_valid),
			.w_wr_rd(retire_rd),
			.w_wr_data(retire_data),
			.flush(flush),
			.operand(opnd[i])
		);
	end

	exec_stage u_exec (
		.clk(clk),
		.rst(rst),
		.d_valid(d_valid),
		.d_instr(d_instr),
		.d_pc(d_pc),
		.opnd(opnd),
		.flush(flush),
		.br_target(br_target),
		.x_wr_en(x_wr_en),
		.x_wr_rd(x_wr_rd),
		.x_wr_data(x_wr_data),
		.w_wr_en(retire_valid),
		.w_wr_rd(retire_rd),
		.w_wr_data(retire_data),
		.flags(flags)
	);

endmodule

`default_nettype wire

// File: dv/core_chk.sv
// core_chk: bound assertions on the APB slave port, the retire port and branch flushes
`default_nettype none
`timescale 1ns/1ns

module core_chk (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pslverr,
	input logic retire_valid,
	input logic flush
);

	int fails = 0; // failed assertion count

	// access cycle must come straight after a setup cycle
	a_access_after_setup: assert property (@(posedge clk)
		$rose(penable) |-> $past(psel && !penable))
		else begin
			fails++;
			$error("penable rose without a preceding setup cycle");
		end

	a_penable_with_psel: assert property (@(posedge clk) penable |-> psel)
		else begin
			fails++;
			$error("penable high while psel low");
		end

	a_err_in_access: assert property (@(posedge clk) pslverr |-> (psel && penable))
		else begin
			fails++;
			$error("pslverr high outside an access cycle");
		end

	// covers the reset cycles and the one right after
	a_quiet_reset: assert property (@(posedge clk) rst |=> !retire_valid ##1 !retire_valid)
		else begin
			fails++;
			$error("retire_valid high during or just after reset");
		end

	a_single_flush: assert property (@(posedge clk) disable iff (rst) flush |=> !flush)
		else begin
			fails++;
			$error("flush high on two cycles in a row");
		end

endmodule

bind core_top core_chk u_chk (
	.clk(clk),
	.rst(rst),
	.psel(psel),
	.penable(penable),
	.pslverr(pslverr),
	.retire_valid(retire_valid),
	.flush(flush)
);

`default_nettype wire

// File: dv/core_tb.sv
// core_tb: loads programs over APB, runs them and checks retirements against an ISA model
`default_nettype none
`timescale 1ns/1ns

module core_tb;

	import arm_lite_pkg::*;

	localparam int DEPTH = 64;
	localparam int CLK_PERIOD = 20;
	localparam int N_RUNS = 5; // APB test plus four programs
	localparam int WATCHDOG_CYCLES = N_RUNS * (8 * DEPTH + 100);
	localparam logic [31:0] FILL_WORD = 32'hF000_0000; // NV condition never executes
	localparam logic [3:0] DP_OPS [9] = '{OP_AND, OP_EOR, OP_SUB, OP_RSB, OP_ADD,
		OP_ORR, OP_MOV, OP_BIC, OP_CMP};

	logic clk;
	logic rst;
	logic run;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic retire_valid;
	logic [3:0] retire_rd;
	logic [31:0] retire_data;
	logic [3:0] flags;

	integer seed;
	int errors;
	int prog_len;
	int got_count;
	logic checking;
	logic [31:0] prog [DEPTH];
	logic [3:0] exp_rd [$];
	logic [31:0] exp_data [$];
	logic [3:0] exp_flags;

	core_top #(.PROG_DEPTH(DEPTH)) dut (
		.clk(clk),
		.rst(rst),
		.run(run),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.retire_valid(retire_valid),
		.retire_rd(retire_rd),
		.retire_data(retire_data),
		.flags(flags)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the core did not retire the expected writes in time");
		$display("*** TEST FAILED ***");
		$fatal(1);
	end

	function automatic logic [31:0] dp_word(input logic [3:0] cond, input logic imm,
			input logic [3:0] op, input logic s, input logic [3:0] rn, input logic [3:0] rd,
			input logic [11:0] op2);
		instr_u w;
		w.dp.cond = cond;
		w.dp.fmt = 2'b00;
		w.dp.imm = imm;
		w.dp.opcode = op;
		w.dp.s = s;
		w.dp.rn = rn;
		w.dp.rd = rd;
		{w.dp.rot, w.dp.imm_hi, w.dp.rm} = op2; // rotate and imm8, or Rm alone
		return w;
	endfunction

	function automatic logic [31:0] mul_word(input logic acc, input logic s, input logic [3:0] rd,
			input logic [3:0] rn, input logic [3:0] rs, input logic [3:0] rm);
		instr_u w;
		w.mul.cond = COND_AL;
		w.mul.fmt = 6'b000000;
		w.mul.acc = acc;
		w.mul.s = s;
		w.mul.rd = rd;
		w.mul.rn = rn;
		w.mul.rs = rs;
		w.mul.tag = 4'b1001;
		w.mul.rm = rm;
		return w;
	endfunction

	function automatic logic [31:0] br_word(input logic [3:0] cond, input logic link,
			input logic [23:0] off);
		instr_u w;
		w.br.cond = cond;
		w.br.fmt = 3'b101;
		w.br.link = link;
		w.br.offset = off;
		return w;
	endfunction

	function automatic logic cond_ok(input logic [3:0] c, input logic n, input logic z,
			input logic cf, input logic v);
		case (c)
			4'h0: return z;
			4'h1: return !z;
			4'h2: return cf;
			4'h3: return !cf;
			4'h4: return n;
			4'h5: return !n;
			4'h6: return v;
			4'h7: return !v;
			4'h8: return cf && !z;
			4'h9: return !cf || z;
			4'hA: return n == v;
			4'hB: return n != v;
			4'hC: return !z && (n == v);
			4'hD: return z || (n != v);
			4'hE: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// instruction-set model that fills the expected write list and final NZCV
	function automatic void model_program();
		logic [31:0] regs [16];
		logic n;
		logic z;
		logic cf;
		logic v;
		logic [31:0] pc;
		instr_u ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic carry;
		logic ovf;
		logic sc;
		logic arith;
		int steps;
		for (int i = 0; i < 16; i++) regs[i] = '0;
		{n, z, cf, v} = 4'b0000;
		exp_rd.delete();
		exp_data.delete();
		pc = '0;
		steps = 0;
		while (pc < DEPTH * 4 && steps < 4096) begin
			ins = prog[pc[31:2]];
			steps++;
			if (!cond_ok(ins.dp.cond, n, z, cf, v)) begin
				pc = pc + 4;
			end else if (ins.mul.fmt == 6'd0 && ins.mul.tag == 4'b1001) begin
				res = regs[ins.mul.rm] * regs[ins.mul.rs] + (ins.mul.acc ? regs[ins.mul.rn] : 32'd0);
				regs[ins.mul.rd] = res;
				exp_rd.push_back(ins.mul.rd);
				exp_data.push_back(res);
				if (ins.mul.s) begin
					n = res[31];
					z = (res == 32'd0);
				end
				pc = pc + 4;
			end else if (ins.br.fmt == 3'b101) begin
				if (ins.br.link) begin
					regs[14] = pc + 4;
					exp_rd.push_back(4'd14);
					exp_data.push_back(pc + 4);
				end
				pc = pc + 8 + {{6{ins.br.offset[23]}}, ins.br.offset, 2'b00};
			end else begin
				a = regs[ins.dp.rn];
				b = ins.dp.imm ? ror32({24'd0, ins.dp.imm_hi, ins.dp.rm}, 2 * ins.dp.rot)
					: regs[ins.dp.rm];
				sc = (ins.dp.imm && ins.dp.rot != 4'd0) ? b[31] : cf;
				arith = 1'b1;
				carry = 1'b0;
				ovf = 1'b0;
				case (ins.dp.opcode)
					OP_ADD: begin
						{carry, res} = {1'b0, a} + {1'b0, b};
						ovf = (a[31] == b[31]) && (res[31] != a[31]);
					end
					OP_SUB, OP_CMP: begin
						res = a - b;
						carry = (a >= b); // no borrow
						ovf = (a[31] != b[31]) && (res[31] != a[31]);
					end
					OP_RSB: begin
						res = b - a;
						carry = (b >= a);
						ovf = (a[31] != b[31]) && (res[31] != b[31]);
					end
					default: begin
						arith = 1'b0;
						case (ins.dp.opcode)
							OP_AND: res = a & b;
							OP_EOR: res = a ^ b;
							OP_ORR: res = a | b;
							OP_BIC: res = a & ~b;
							default: res = b; // MOV
						endcase
					end
				endcase
				if (ins.dp.opcode != OP_CMP) begin
					regs[ins.dp.rd] = res;
					exp_rd.push_back(ins.dp.rd);
					exp_data.push_back(res);
				end
				if (ins.dp.s) begin
					n = res[31];
					z = (res == 32'd0);
					cf = arith ? carry : sc;
					v = arith ? ovf : v;
				end
				pc = pc + 4;
			end
		end
		exp_flags = {n, z, cf, v};
	endfunction

	function automatic logic [31:0] ror32(input logic [31:0] val, input int amt);
		return (val >> amt) | (val << (32 - amt));
	endfunction

	task automatic report_failure(input string msg);
		errors++;
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_write(input logic [3:0] got_rd, input logic [31:0] got_data,
			input logic [3:0] want_rd, input logic [31:0] want_data);
		if (got_rd !== want_rd || got_data !== want_data)
			report_failure($sformatf("Mismatch at %0t ns: retired r%0d = %h, expected r%0d = %h",
				$time, got_rd, got_data, want_rd, want_data));
	endtask

	task automatic check_flags(input logic [3:0] got, input logic [3:0] want);
		if (got !== want)
			report_failure($sformatf("Mismatch at %0t ns: flags NZCV = %b, expected %b",
				$time, got, want));
	endtask

	task automatic check_word(input logic [31:0] addr, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want)
			report_failure($sformatf("Mismatch at %0t ns: prdata at %h = %h, expected %h",
				$time, addr, got, want));
	endtask

	task automatic check_err(input logic [31:0] addr, input logic got, input logic want);
		if (got !== want)
			report_failure($sformatf("Mismatch at %0t ns: pslverr at %h = %b, expected %b",
				$time, addr, got, want));
	endtask

	task automatic check_ready(input logic [31:0] addr, input logic got);
		if (got !== 1'b1)
			report_failure($sformatf("Mismatch at %0t ns: pready at %h = %b, expected 1",
				$time, addr, got));
	endtask

	// setup on one falling edge and access on the next with a mid-access sample
	task automatic apb_transfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		#(CLK_PERIOD / 4);
		rdata = prdata;
		err = pslverr;
		check_ready(addr, pready);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	always @(negedge clk) begin
		if (dut.u_chk.fails != 0) begin
			report_failure("An assertion in the bound checker failed");
		end else if (checking && retire_valid) begin
			if (got_count >= exp_rd.size())
				report_failure($sformatf("Unexpected extra retirement of r%0d at %0t ns",
					retire_rd, $time));
			else begin
				check_write(retire_rd, retire_data, exp_rd[got_count], exp_data[got_count]);
				got_count++;
			end
		end
	end

	task automatic clear_program();
		for (int i = 0; i < DEPTH; i++) prog[i] = FILL_WORD;
		prog_len = 0;
	endtask

	task automatic append_word(input logic [31:0] word);
		prog[prog_len] = word;
		prog_len++;
	endtask

	task automatic apb_load_test();
		logic [31:0] rdata;
		logic err;
		for (int i = 0; i < DEPTH; i++) begin
			prog[i] = $random(seed);
			apb_transfer(1'b1, i * 4, prog[i], rdata, err);
			check_err(i * 4, err, 1'b0);
		end
		for (int i = 0; i < DEPTH; i++) begin
			apb_transfer(1'b0, i * 4, '0, rdata, err);
			check_word(i * 4, rdata, prog[i]);
			check_err(i * 4, err, 1'b0);
		end
		apb_transfer(1'b1, DEPTH * 4, ~prog[0], rdata, err); // aliases word 0 if decoded wrongly
		check_err(DEPTH * 4, err, 1'b1);
		apb_transfer(1'b0, 0, '0, rdata, err);
		check_word(0, rdata, prog[0]);
		apb_transfer(1'b0, DEPTH * 4 + 4, '0, rdata, err);
		check_err(DEPTH * 4 + 4, err, 1'b1);
	endtask

	task automatic build_dp_program();
		logic [31:0] rnd;
		logic [3:0] op;
		logic [3:0] rd;
		logic [3:0] prev;
		logic [3:0] prev2;
		clear_program();
		for (int r = 0; r < 4; r++) begin
			rnd = $random(seed);
			append_word(dp_word(COND_AL, 1'b1, OP_MOV, 1'b0, 4'd0, 4'(r), rnd[11:0]));
		end
		prev = 4'd3;
		prev2 = 4'd2;
		for (int i = 0; i < 24; i++) begin
			rnd = $random(seed);
			op = DP_OPS[i % 9]; // every opcode in turn
			rd = 4'(rnd[15:12] % 13);
			append_word(dp_word(COND_AL, rnd[16], op, rnd[17] || op == OP_CMP, prev, rd,
				rnd[16] ? rnd[11:0] : {8'd0, prev2})); // each one reads the last result
			if (op != OP_CMP) begin
				prev2 = prev;
				prev = rd;
			end
		end
	endtask

	task automatic build_flag_program();
		logic [31:0] rnd;
		logic [3:0] setup_op;
		clear_program();
		for (int r = 1; r < 5; r++) begin
			rnd = $random(seed);
			append_word(dp_word(COND_AL, 1'b1, OP_MOV, 1'b0, 4'd0, 4'(r), rnd[11:0]));
		end
		for (int c = 0; c < 15; c++) begin
			rnd = $random(seed);
			case (rnd[18:16] % 5)
				0: setup_op = OP_SUB;
				1: setup_op = OP_ADD;
				2: setup_op = OP_CMP;
				3: setup_op = OP_RSB;
				default: setup_op = OP_AND;
			endcase
			append_word(dp_word(COND_AL, rnd[20], setup_op, 1'b1, 4'(1 + rnd[22:21]), 4'd5,
				rnd[20] ? rnd[11:0] : {8'd0, 4'(1 + rnd[25:24])}));
			append_word(dp_word(4'(c), 1'b1, OP_ADD, 1'b0, 4'd6, 4'd6, 12'(c + 1)));
		end
	endtask

	task automatic build_mul_program();
		logic [31:0] rnd;
		logic [3:0] last;
		logic [3:0] rd;
		clear_program();
		for (int r = 1; r < 5; r++) begin
			rnd = $random(seed);
			append_word(dp_word(COND_AL, 1'b1, OP_MOV, 1'b0, 4'd0, 4'(r), {4'd0, rnd[7:0]}));
			append_word(dp_word(COND_AL, 1'b1, OP_ORR, 1'b0, 4'(r), 4'(r), {4'd4, rnd[15:8]}));
		end
		last = 4'd4;
		for (int i = 0; i < 10; i++) begin
			rnd = $random(seed);
			rd = 4'(1 + rnd[2:0]);
			append_word(mul_word(rnd[4], rnd[5], rd, 4'(1 + rnd[10:8]), 4'(1 + rnd[14:12]), last));
			last = rd;
		end
	endtask

	task automatic build_branch_program();
		clear_program();
		append_word(dp_word(COND_AL, 1'b1, OP_MOV, 1'b0, 4'd0, 4'd1, 12'd3)); // loop count
		append_word(br_word(COND_AL, 1'b0, 24'd2)); // to word 5
		append_word(dp_word(COND_AL, 1'b1, OP_MOV, 1'b0, 4'd0, 4'd9, 12'hA1));
		append_word(dp_word(COND_AL, 1'b1, OP_MOV, 1'b0, 4'd0, 4'd9, 12'hA2));
		append_word(dp_word(COND_AL, 1'b1, OP_MOV, 1'b0, 4'd0, 4'd9, 12'hA3));
		append_word(dp_word(COND_AL, 1'b1, OP_SUB, 1'b1, 4'd1, 4'd1, 12'd1));
		append_word(dp_word(COND_AL, 1'b1, OP_ADD, 1'b0, 4'd2, 4'd2, 12'd5));
		append_word(br_word(COND_NE, 1'b0, 24'hFF_FFFC)); // back to word 5
		append_word(br_word(COND_NE, 1'b0, 24'd4)); // not taken since Z is set
		append_word(br_word(COND_AL, 1'b1, 24'd1)); // BL to word 12
		append_word(dp_word(COND_AL, 1'b1, OP_MOV, 1'b0, 4'd0, 4'd10, 12'hB1));
		append_word(dp_word(COND_AL, 1'b1, OP_MOV, 1'b0, 4'd0, 4'd10, 12'hB2));
		append_word(dp_word(COND_AL, 1'b0, OP_MOV, 1'b0, 4'd0, 4'd3, 12'd14));
		append_word(dp_word(COND_AL, 1'b1, OP_ADD, 1'b0, 4'd14, 4'd4, 12'd1));
		append_word(br_word(COND_AL, 1'b0, 24'd3)); // to word 19
		append_word(dp_word(COND_AL, 1'b1, OP_MOV, 1'b0, 4'd0, 4'd11, 12'hC1));
		append_word(dp_word(COND_AL, 1'b1, OP_MOV, 1'b0, 4'd0, 4'd11, 12'hC2));
		append_word(dp_word(COND_AL, 1'b1, OP_MOV, 1'b0, 4'd0, 4'd12, 12'h55));
		append_word(br_word(COND_AL, 1'b0, 24'd1)); // to word 21
		append_word(dp_word(COND_AL, 1'b1, OP_MOV, 1'b0, 4'd0, 4'd11, 12'h33));
		append_word(br_word(COND_AL, 1'b0, 24'hFF_FFFB)); // back to word 17
		append_word(dp_word(COND_AL, 1'b1, OP_ADD, 1'b0, 4'd12, 4'd5, 12'd1));
	endtask

	task automatic run_program();
		logic [31:0] rdata;
		logic err;
		model_program();
		for (int i = 0; i < DEPTH; i++) begin
			apb_transfer(1'b1, i * 4, prog[i], rdata, err);
			check_err(i * 4, err, 1'b0);
		end
		@(negedge clk);
		rst = 1'b1;
		got_count = 0;
		checking = 1'b1;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		run = 1'b1;
		wait (got_count == exp_rd.size());
		repeat (DEPTH + 8) @(negedge clk); // pc runs past the end and flags settle
		check_flags(flags, exp_flags);
		run = 1'b0;
		checking = 1'b0;
	endtask

	initial begin
		seed = 99;
		errors = 0;
		got_count = 0;
		checking = 1'b0;
		rst = 1'b1;
		run = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		apb_load_test();
		build_dp_program();
		run_program();
		build_flag_program();
		run_program();
		build_mul_program();
		run_program();
		build_branch_program();
		run_program();
		if (errors == 0 && dut.u_chk.fails == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
src/arm_lite_pkg.sv
src/prog_mem.sv
src/fetch_stage.sv
src/reg_file.sv
src/operand_fwd.sv
src/exec_stage.sv
src/core_top.sv
dv/core_chk.sv
dv/core_tb.sv
